/* Makefile */
SIM        = verilator
TOP        = rob_tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/rob_entry_store.sv */
module rob_entry_store #(
  parameter int ROB_DEPTH = 8,
  localparam int IDX_W = $clog2(ROB_DEPTH)
) (
  input  logic                             clk_in,
  input  logic                             rst_in,
  input  logic                             push,
  input  logic                             run_en,
  input  rob_pkg::rob_issue_t              issue,
  input  logic [IDX_W-1:0]                 head,
  input  logic [IDX_W-1:0]                 tail,
  input  logic                             empty,
  input  rob_pkg::rob_cdb_t                cdb,
  input  logic [IDX_W-1:0]                 cdb_idx,
  input  logic [IDX_W-1:0]                 rd1_idx,
  input  logic [IDX_W-1:0]                 rd2_idx,
  output logic [rob_pkg::XLEN-1:0]         rd1_value,
  output logic [rob_pkg::XLEN-1:0]         rd2_value,
  output logic                             rd1_ready,
  output logic                             rd2_ready,
  output rob_pkg::rob_commit_t             commit,
  output logic                             commit_out,
  output logic                             store_valid,
  input  logic                             store_read,
  output logic                             pop,
  output logic                             mispredict,
  output logic [IDX_W-1:0]                 restore_tail,
  output logic [rob_pkg::XLEN-1:0]         flush_pc,
  output logic [rob_pkg::NUM_ARCH_REGS-1:0] flush_mask,
  output rob_pkg::rob_entry_t              entries [ROB_DEPTH]
);

  import rob_pkg::*;

  localparam int REG_W = $clog2(NUM_ARCH_REGS);

  // entry arrays, only the ready flags are control state
  itype_e                  itype_q [ROB_DEPTH];
  logic [XLEN-1:0]         value_q [ROB_DEPTH];
  logic [XLEN-1:0]         dest_q  [ROB_DEPTH];
  logic [ROB_DEPTH-1:0]    ready_q;

  logic                    cdb_wr;
  logic                    cdb_is_branch;
  logic [NUM_ARCH_REGS-1:0] squash_mask;

  // classes that own a destination register
  function automatic logic writes_reg(input itype_e t);
    return t inside {OP, OPIMM, LUI, AUIPC, JAL, JALR, LOAD, MUL, DIV};
  endfunction

  // cdb ignored during the flush cycle
  assign cdb_wr        = cdb.valid && run_en;
  assign cdb_is_branch = (itype_q[cdb_idx] == BRANCH);

  // stored prediction vs actual outcome
  assign mispredict = cdb_wr && cdb_is_branch && (value_q[cdb_idx][0] != cdb.value[0]);

  // branch itself survives, tail lands just past it
  assign restore_tail = cdb_idx + 1'b1;

  // walk the squashed region, branch+1 up to the old tail
  always_comb begin
    logic [IDX_W-1:0] idx;
    logic             live;
    squash_mask = '0;
    live        = 1'b1;
    for (int i = 1; i < ROB_DEPTH; i++) begin
      idx = cdb_idx + IDX_W'(i);
      if (idx == tail) begin
        live = 1'b0;
      end
      if (live && writes_reg(itype_q[idx])) begin
        squash_mask[dest_q[idx][REG_W-1:0]] = 1'b1;
      end
    end
  end

  // ready flags, cleared on issue and set by the cdb
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ready_q <= '0;
    end else begin
      if (push) begin
        ready_q[tail] <= 1'b0;
      end
      // branches go ready too, so they can commit
      if (cdb_wr) begin
        ready_q[cdb_idx] <= 1'b1;
      end
    end
  end

  // payload writes
  always_ff @(posedge clk_in) begin
    if (push) begin
      itype_q[tail] <= issue.itype;
      value_q[tail] <= issue.value;
      dest_q[tail]  <= issue.dest;
    end
    // branch keeps its prediction bit
    if (cdb_wr && !cdb_is_branch) begin
      value_q[cdb_idx] <= cdb.value;
      // store address = base from cdb + stored offset
      if (itype_q[cdb_idx] == STORE) begin
        dest_q[cdb_idx] <= dest_q[cdb_idx] + cdb.dest;
      end
    end
    // redirect payload, shown while flush_out is high
    if (mispredict) begin
      flush_pc   <= dest_q[cdb_idx];
      flush_mask <= squash_mask;
    end
  end

  // decode operand lookup
  assign rd1_value = value_q[rd1_idx];
  assign rd1_ready = ready_q[rd1_idx];
  assign rd2_value = value_q[rd2_idx];
  assign rd2_ready = ready_q[rd2_idx];

  // head readout
  assign commit.itype = itype_q[head];
  assign commit.value = value_q[head];
  assign commit.dest  = dest_q[head];

  // stores leave through the store path, all others commit
  assign commit_out  = !empty && ready_q[head] && (itype_q[head] != STORE);
  assign store_valid = !empty && ready_q[head] && (itype_q[head] == STORE);
  assign pop         = commit_out || (store_valid && store_read);

  // flat view for the load check
  always_comb begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      entries[i].itype = itype_q[i];
      entries[i].value = value_q[i];
      entries[i].dest  = dest_q[i];
      entries[i].ready = ready_q[i];
    end
  end

endmodule

/* design/rob_flush_fsm.sv */
module rob_flush_fsm (
  input  logic clk_in,
  input  logic rst_in,
  input  logic mispredict,
  output logic run_en,
  output logic restore,
  output logic flush_out
);

  import rob_pkg::*;

  flush_state_e state_q;
  flush_state_e state_d;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN: begin
        // wrong direction seen on the cdb
        if (mispredict) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        // flush lasts a single cycle
        state_d = RUN;
      end
      default: begin
        state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // issue and cdb only accepted in RUN
  assign run_en = (state_q == RUN);

  // tail restore pulse on the mispredict edge
  assign restore = (state_q == RUN) && mispredict;

  // redirect visible for the whole flush cycle
  assign flush_out = (state_q == FLUSH);

endmodule

/* design/rob_load_check.sv */
module rob_load_check #(
  parameter int ROB_DEPTH = 8,
  parameter int LB_DEPTH = 3,
  localparam int IDX_W = $clog2(ROB_DEPTH)
) (
  input  logic [IDX_W-1:0]    head,
  input  rob_pkg::rob_entry_t entries [ROB_DEPTH],
  input  logic [IDX_W-1:0]    lb_idx [LB_DEPTH],
  input  rob_pkg::lb_query_t  lb_query [LB_DEPTH],
  output logic [LB_DEPTH-1:0] can_load
);

  import rob_pkg::*;

  // per slot: stores older than the load
  logic [LB_DEPTH-1:0] older_unresolved;
  logic [LB_DEPTH-1:0] older_alias;

  // scan from the head toward the load, in age order
  always_comb begin
    logic [IDX_W-1:0] idx;
    logic             older;
    for (int s = 0; s < LB_DEPTH; s++) begin
      older_unresolved[s] = 1'b0;
      older_alias[s]      = 1'b0;
      older               = 1'b1;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        // wraps past the last slot
        idx = head + IDX_W'(i);
        // the load itself and everything younger stop the scan
        if (idx == lb_idx[s]) begin
          older = 1'b0;
        end
        if (older && (entries[idx].itype == STORE)) begin
          // address not known yet
          if (!entries[idx].ready) begin
            older_unresolved[s] = 1'b1;
          end
          // resolved store to the same word
          else if (entries[idx].dest == lb_query[s].addr) begin
            older_alias[s] = 1'b1;
          end
        end
      end
    end
  end

  // load may go once every older store is known and disjoint
  assign can_load = ~(older_unresolved | older_alias);

endmodule

/* design/rob_pkg.sv */
package rob_pkg;

  // datapath width of the core
  localparam int XLEN = 32;

  // architectural register count, one flush mask bit each
  localparam int NUM_ARCH_REGS = 32;

  // instruction class held in each entry
  typedef enum logic [3:0] {
    OP     = 4'd0,
    OPIMM  = 4'd1,
    LUI    = 4'd2,
    AUIPC  = 4'd3,
    JAL    = 4'd4,
    JALR   = 4'd5,
    LOAD   = 4'd6,
    STORE  = 4'd7,
    BRANCH = 4'd8,
    MUL    = 4'd9,
    DIV    = 4'd10
  } itype_e;

  // flush sequencer states
  typedef enum logic {
    RUN   = 1'b0,
    FLUSH = 1'b1
  } flush_state_e;

  // issue request into the tail
  // branch: value[0] is the prediction, dest the redirect target
  // store: dest is the address offset
  // others: dest is the register index
  typedef struct packed {
    logic             valid;
    itype_e           itype;
    logic [XLEN-1:0]  value;
    logic [XLEN-1:0]  dest;
  } rob_issue_t;

  // result broadcast, entry index on its own port
  // dest carries the store base, value[0] the branch outcome
  typedef struct packed {
    logic             valid;
    logic [XLEN-1:0]  value;
    logic [XLEN-1:0]  dest;
  } rob_cdb_t;

  // head entry as seen by commit and store path
  typedef struct packed {
    itype_e           itype;
    logic [XLEN-1:0]  value;
    logic [XLEN-1:0]  dest;
  } rob_commit_t;

  // one buffer slot, exported for the load check
  typedef struct packed {
    itype_e           itype;
    logic [XLEN-1:0]  value;
    logic [XLEN-1:0]  dest;
    logic             ready;
  } rob_entry_t;

  // address of one load-buffer slot
  typedef struct packed {
    logic [XLEN-1:0]  addr;
  } lb_query_t;

endpackage

/* design/rob_ptr_ctrl.sv */
module rob_ptr_ctrl #(
  parameter int ROB_DEPTH = 8,
  localparam int IDX_W = $clog2(ROB_DEPTH)
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             issue_valid,
  input  logic             run_en,
  input  logic             pop,
  input  logic             restore,
  input  logic [IDX_W-1:0] restore_tail,
  output logic [IDX_W-1:0] head,
  output logic [IDX_W-1:0] tail,
  output logic             empty,
  output logic             full,
  output logic             ready,
  output logic             push
);

  // one extra wrap bit on each pointer
  logic [IDX_W:0] head_q;
  logic [IDX_W:0] tail_q;
  logic [IDX_W:0] count;
  // wrap bit of the tail after a restore
  logic           restore_wrap;

  // occupancy from pointer distance
  assign count = tail_q - head_q;
  assign empty = (count == '0);
  assign full  = (count == (IDX_W + 1)'(ROB_DEPTH));

  // no new entries while full or flushing
  assign ready = !full && run_en;
  assign push  = issue_valid && ready;

  assign head = head_q[IDX_W-1:0];
  assign tail = tail_q[IDX_W-1:0];

  // tail only moves back on restore
  // crossing slot 0 backwards flips the wrap bit
  assign restore_wrap = tail_q[IDX_W] ^ (restore_tail > tail_q[IDX_W-1:0]);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      // retire from the head, also during flush
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      // restore wins over a same-cycle issue
      // that issue is younger than the branch anyway
      if (restore) begin
        tail_q <= {restore_wrap, restore_tail};
      end else if (push) begin
        tail_q <= tail_q + 1'b1;
      end
    end
  end

endmodule

/* design/rob_top.sv */
module rob_top #(
  parameter int ROB_DEPTH = 8,
  parameter int LB_DEPTH = 3,
  localparam int IDX_W = $clog2(ROB_DEPTH)
) (
  input  logic                              clk_in,
  input  logic                              rst_in,
  // issue
  input  rob_pkg::rob_issue_t               issue,
  output logic [IDX_W-1:0]                  issue_idx,
  output logic                              ready,
  // result bus
  input  rob_pkg::rob_cdb_t                 cdb,
  input  logic [IDX_W-1:0]                  cdb_idx,
  // decode operand lookup
  input  logic [IDX_W-1:0]                  rd1_idx,
  input  logic [IDX_W-1:0]                  rd2_idx,
  output logic [rob_pkg::XLEN-1:0]          rd1_value,
  output logic                              rd1_ready,
  output logic [rob_pkg::XLEN-1:0]          rd2_value,
  output logic                              rd2_ready,
  // commit
  output logic                              commit_out,
  output rob_pkg::rob_commit_t              commit,
  output logic [IDX_W-1:0]                  commit_idx,
  // store path
  output logic                              store_valid,
  input  logic                              store_read,
  // load disambiguation
  input  logic [IDX_W-1:0]                  lb_idx [LB_DEPTH],
  input  rob_pkg::lb_query_t                lb_query [LB_DEPTH],
  output logic [LB_DEPTH-1:0]               can_load,
  // branch redirect
  output logic                              flush_out,
  output logic [rob_pkg::XLEN-1:0]          flush_pc,
  output logic [rob_pkg::NUM_ARCH_REGS-1:0] flush_mask
);

  // pointer state
  logic [IDX_W-1:0] head;
  logic [IDX_W-1:0] tail;
  logic             empty;
  logic             push;
  logic             pop;

  // flush control
  logic             mispredict;
  logic             run_en;
  logic             restore;
  logic [IDX_W-1:0] restore_tail;

  // slot array for the load check
  rob_pkg::rob_entry_t entries [ROB_DEPTH];

  // next free slot and current head
  assign issue_idx  = tail;
  assign commit_idx = head;

  rob_ptr_ctrl #(.ROB_DEPTH(ROB_DEPTH)) u_ptr_ctrl (
    .clk_in(clk_in), .rst_in(rst_in),
    .issue_valid(issue.valid), .run_en(run_en), .pop(pop),
    .restore(restore), .restore_tail(restore_tail),
    .head(head), .tail(tail), .empty(empty), .full(),
    .ready(ready), .push(push)
  );

  rob_flush_fsm u_flush_fsm (
    .clk_in(clk_in), .rst_in(rst_in), .mispredict(mispredict),
    .run_en(run_en), .restore(restore), .flush_out(flush_out)
  );

  rob_entry_store #(.ROB_DEPTH(ROB_DEPTH)) u_entry_store (
    .clk_in(clk_in), .rst_in(rst_in),
    .push(push), .run_en(run_en), .issue(issue),
    .head(head), .tail(tail), .empty(empty),
    .cdb(cdb), .cdb_idx(cdb_idx),
    .rd1_idx(rd1_idx), .rd2_idx(rd2_idx),
    .rd1_value(rd1_value), .rd2_value(rd2_value),
    .rd1_ready(rd1_ready), .rd2_ready(rd2_ready),
    .commit(commit), .commit_out(commit_out),
    .store_valid(store_valid), .store_read(store_read), .pop(pop),
    .mispredict(mispredict), .restore_tail(restore_tail),
    .flush_pc(flush_pc), .flush_mask(flush_mask),
    .entries(entries)
  );

  rob_load_check #(.ROB_DEPTH(ROB_DEPTH), .LB_DEPTH(LB_DEPTH)) u_load_check (
    .head(head), .entries(entries),
    .lb_idx(lb_idx), .lb_query(lb_query), .can_load(can_load)
  );

endmodule

/* tb.f */
design/rob_pkg.sv
design/rob_ptr_ctrl.sv
design/rob_flush_fsm.sv
design/rob_entry_store.sv
design/rob_load_check.sv
design/rob_top.sv
tb/rob_tb.sv

/* tb/rob_tb.sv */
module rob_tb;

  import rob_pkg::*;

  localparam int ROB_DEPTH  = 8;
  localparam int LB_DEPTH   = 3;
  localparam int IDX_W      = $clog2(ROB_DEPTH);
  // limit on the whole run including reset
  localparam int MAX_CYCLES = 400;

  logic                     clk_in;
  logic                     rst_in;
  rob_issue_t               issue;
  logic [IDX_W-1:0]         issue_idx;
  logic                     ready;
  rob_cdb_t                 cdb;
  logic [IDX_W-1:0]         cdb_idx;
  logic [IDX_W-1:0]         rd1_idx;
  logic [IDX_W-1:0]         rd2_idx;
  logic [XLEN-1:0]          rd1_value;
  logic                     rd1_ready;
  logic [XLEN-1:0]          rd2_value;
  logic                     rd2_ready;
  logic                     commit_out;
  rob_commit_t              commit;
  logic [IDX_W-1:0]         commit_idx;
  logic                     store_valid;
  logic                     store_read;
  logic [IDX_W-1:0]         lb_idx [LB_DEPTH];
  lb_query_t                lb_query [LB_DEPTH];
  logic [LB_DEPTH-1:0]      can_load;
  logic                     flush_out;
  logic [XLEN-1:0]          flush_pc;
  logic [NUM_ARCH_REGS-1:0] flush_mask;

  // reference model in age order with slot indices alongside
  rob_commit_t              model_q[$];
  logic [IDX_W-1:0]         model_idx_q[$];
  // slot the next accepted issue should take
  logic [IDX_W-1:0]         exp_tail;
  logic [15:0]              lfsr_q;
  int                       cycle_count;

  rob_top #(.ROB_DEPTH(ROB_DEPTH), .LB_DEPTH(LB_DEPTH)) dut (.*);

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  // watchdog
  always @(posedge clk_in) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_mask(input string name, input logic [NUM_ARCH_REGS-1:0] exp,
                            input logic [NUM_ARCH_REGS-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected mask %h, actual mask %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_commit(input string name, input rob_commit_t exp, input rob_commit_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %s value %h dest %h, actual %s value %h dest %h", name,
               exp.itype.name(), exp.value, exp.dest, act.itype.name(), act.value, act.dest);
      abort_run();
    end
  endtask

  // galois lfsr stepped once per bit
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_q[0];
    lfsr_q  = lfsr_q >> 1;
    if (out_bit) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out_bit;
  endfunction

  function automatic logic [XLEN-1:0] rand_bits(input int n);
    logic [XLEN-1:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[XLEN-2:0], lfsr_step()};
    end
    return r;
  endfunction

  // inputs change shortly after the edge
  task automatic next_cycle();
    @(posedge clk_in);
    #2;
  endtask

  // one accepted issue recorded in the model
  task automatic issue_one(input string name, input itype_e t, input logic [XLEN-1:0] value,
                           input logic [XLEN-1:0] dest, output logic [IDX_W-1:0] idx);
    rob_commit_t e;
    check_bit(name, 1'b1, ready);
    check_word(name, XLEN'(exp_tail), XLEN'(issue_idx));
    e.itype = t;
    e.value = value;
    e.dest  = dest;
    model_q.push_back(e);
    model_idx_q.push_back(exp_tail);
    idx         = exp_tail;
    exp_tail    = exp_tail + 1'b1;
    issue.valid = 1'b1;
    issue.itype = t;
    issue.value = value;
    issue.dest  = dest;
    next_cycle();
    issue.valid = 1'b0;
  endtask

  // result on the cdb for one slot
  task automatic cdb_write(input logic [IDX_W-1:0] idx, input logic [XLEN-1:0] value,
                           input logic [XLEN-1:0] base);
    rob_commit_t e;
    for (int i = 0; i < model_q.size(); i++) begin
      e = model_q[i];
      // branches keep the predicted direction
      if (model_idx_q[i] == idx && e.itype != BRANCH) begin
        e.value = value;
        // store address is offset plus base
        if (e.itype == STORE) begin
          e.dest = e.dest + base;
        end
        model_q[i] = e;
      end
    end
    cdb.valid = 1'b1;
    cdb.value = value;
    cdb.dest  = base;
    cdb_idx   = idx;
    next_cycle();
    cdb.valid = 1'b0;
  endtask

  // wait for the head and compare it with the oldest model entry
  task automatic retire_head(input string name);
    rob_commit_t      exp_e;
    logic [IDX_W-1:0] exp_idx;
    exp_e   = model_q.pop_front();
    exp_idx = model_idx_q.pop_front();
    while (!commit_out && !store_valid) begin
      next_cycle();
    end
    check_bit(name, exp_e.itype == STORE, store_valid);
    check_commit(name, exp_e, commit);
    check_word(name, XLEN'(exp_idx), XLEN'(commit_idx));
    // stores need the store path to take them
    store_read = store_valid;
    next_cycle();
    store_read = 1'b0;
  endtask

  task automatic drain(input string name);
    while (model_q.size() > 0) begin
      retire_head(name);
    end
  endtask

  task automatic test_reset_state();
    check_bit("reset_state", 1'b1, ready);
    check_bit("reset_state", 1'b0, commit_out);
    check_bit("reset_state", 1'b0, store_valid);
    check_bit("reset_state", 1'b0, flush_out);
    check_word("reset_state", '0, XLEN'(issue_idx));
  endtask

  task automatic test_in_order_commit();
    logic [IDX_W-1:0] idx [5];
    for (int i = 0; i < 5; i++) begin
      issue_one("in_order_commit", OP, rand_bits(32), rand_bits(5), idx[i]);
    end
    // youngest first and the head last
    for (int i = 4; i >= 0; i--) begin
      cdb_write(idx[i], rand_bits(32), '0);
    end
    // one commit per cycle from here on
    for (int i = 0; i < 5; i++) begin
      check_bit("in_order_commit", 1'b1, commit_out);
      retire_head("in_order_commit");
    end
    check_bit("in_order_commit", 1'b0, commit_out);
  endtask

  task automatic test_full_backpressure();
    logic [IDX_W-1:0] idx;
    int               accepted;
    accepted = 0;
    while (ready && accepted <= ROB_DEPTH) begin
      issue_one("full_backpressure", OPIMM, rand_bits(32), rand_bits(5), idx);
      accepted++;
    end
    check_word("full_backpressure", XLEN'(ROB_DEPTH), XLEN'(accepted));
    // dropped while full
    issue.valid = 1'b1;
    issue.itype = OP;
    next_cycle();
    issue.valid = 1'b0;
    check_bit("full_backpressure", 1'b0, ready);
    check_word("full_backpressure", XLEN'(exp_tail), XLEN'(issue_idx));
    // free the head slot
    cdb_write(model_idx_q[0], rand_bits(32), '0);
    retire_head("full_backpressure");
    check_bit("full_backpressure", 1'b1, ready);
    for (int i = model_idx_q.size() - 1; i >= 0; i--) begin
      cdb_write(model_idx_q[i], rand_bits(32), '0);
    end
    drain("full_backpressure");
  endtask

  task automatic test_store_path();
    logic [IDX_W-1:0] idx;
    logic [XLEN-1:0]  offset;
    logic [XLEN-1:0]  base;
    offset = rand_bits(12);
    base   = rand_bits(32);
    issue_one("store_path", STORE, '0, offset, idx);
    cdb_write(idx, rand_bits(32), base);
    // head held without store_read
    repeat (3) begin
      check_bit("store_path", 1'b1, store_valid);
      check_bit("store_path", 1'b0, commit_out);
      check_word("store_path", offset + base, commit.dest);
      check_word("store_path", XLEN'(idx), XLEN'(commit_idx));
      next_cycle();
    end
    retire_head("store_path");
    check_bit("store_path", 1'b0, store_valid);
  endtask

  task automatic test_operand_lookup();
    logic [IDX_W-1:0] idx_a;
    logic [IDX_W-1:0] idx_b;
    logic [XLEN-1:0]  val_a;
    logic [XLEN-1:0]  val_b;
    issue_one("operand_lookup", MUL, rand_bits(32), rand_bits(5), idx_a);
    issue_one("operand_lookup", DIV, rand_bits(32), rand_bits(5), idx_b);
    rd1_idx = idx_a;
    rd2_idx = idx_b;
    #1;
    check_bit("operand_lookup", 1'b0, rd1_ready);
    check_bit("operand_lookup", 1'b0, rd2_ready);
    val_b = rand_bits(32);
    cdb_write(idx_b, val_b, '0);
    check_bit("operand_lookup", 1'b1, rd2_ready);
    check_word("operand_lookup", val_b, rd2_value);
    check_bit("operand_lookup", 1'b0, rd1_ready);
    val_a = rand_bits(32);
    cdb_write(idx_a, val_a, '0);
    check_bit("operand_lookup", 1'b1, rd1_ready);
    check_word("operand_lookup", val_a, rd1_value);
    drain("operand_lookup");
  endtask

  task automatic test_load_check();
    logic [IDX_W-1:0] idx_s;
    logic [IDX_W-1:0] idx_l;
    logic [IDX_W-1:0] idx_y;
    logic [XLEN-1:0]  off_s;
    logic [XLEN-1:0]  off_y;
    logic [XLEN-1:0]  addr_s;
    logic [XLEN-1:0]  addr_l;
    off_s  = rand_bits(12);
    off_y  = rand_bits(12);
    addr_s = off_s + rand_bits(32);
    addr_l = addr_s ^ 32'h40;
    // older store then the load then a younger store
    issue_one("load_check", STORE, '0, off_s, idx_s);
    issue_one("load_check", LOAD, '0, rand_bits(5), idx_l);
    issue_one("load_check", STORE, '0, off_y, idx_y);
    // slots 1 and 2 sit at the head with nothing older
    lb_idx[0]        = idx_l;
    lb_query[0].addr = addr_l;
    lb_idx[1]        = idx_s;
    lb_query[1].addr = addr_s;
    lb_idx[2]        = idx_s;
    lb_query[2].addr = addr_l;
    #1;
    check_bit("load_check", 1'b0, can_load[0]);
    check_bit("load_check", 1'b1, can_load[1]);
    check_bit("load_check", 1'b1, can_load[2]);
    // older store resolves elsewhere
    cdb_write(idx_s, rand_bits(32), addr_s - off_s);
    check_bit("load_check", 1'b1, can_load[0]);
    lb_query[0].addr = addr_s;
    #1;
    check_bit("load_check", 1'b0, can_load[0]);
    // younger store aliasing the load is ignored
    lb_query[0].addr = addr_l;
    cdb_write(idx_y, rand_bits(32), addr_l - off_y);
    check_bit("load_check", 1'b1, can_load[0]);
    cdb_write(idx_l, rand_bits(32), '0);
    drain("load_check");
  endtask

  task automatic test_mispredict_flush();
    logic [IDX_W-1:0]         idx_br;
    logic [IDX_W-1:0]         idx;
    logic [IDX_W-1:0]         exp_next;
    logic [XLEN-1:0]          target;
    logic [XLEN-1:0]          rd;
    logic [NUM_ARCH_REGS-1:0] exp_mask;
    target   = rand_bits(32);
    exp_mask = '0;
    // predicted taken
    issue_one("mispredict_flush", BRANCH, 32'd1, target, idx_br);
    for (int i = 0; i < 3; i++) begin
      rd = rand_bits(5);
      exp_mask[rd[4:0]] = 1'b1;
      issue_one("mispredict_flush", OP, rand_bits(32), rd, idx);
    end
    exp_next = idx_br + 1'b1;
    // actual direction not taken
    cdb_write(idx_br, 32'd0, '0);
    check_bit("mispredict_flush", 1'b1, flush_out);
    check_bit("mispredict_flush", 1'b0, ready);
    check_word("mispredict_flush", target, flush_pc);
    check_mask("mispredict_flush", exp_mask, flush_mask);
    check_word("mispredict_flush", XLEN'(exp_next), XLEN'(issue_idx));
    // squashed entries leave the model but the branch stays
    repeat (3) begin
      model_q.delete(model_q.size() - 1);
      model_idx_q.delete(model_idx_q.size() - 1);
    end
    exp_tail = exp_next;
    // branch commits during the flush cycle
    check_bit("mispredict_flush", 1'b1, commit_out);
    retire_head("mispredict_flush");
    check_bit("mispredict_flush", 1'b0, flush_out);
    check_bit("mispredict_flush", 1'b1, ready);
    issue_one("mispredict_flush", OP, rand_bits(32), rand_bits(5), idx);
    cdb_write(idx, rand_bits(32), '0);
    drain("mispredict_flush");
  endtask

  initial begin
    lfsr_q      = 16'd40396;
    cycle_count = 0;
    exp_tail    = '0;
    rst_in      = 1'b1;
    issue       = '0;
    cdb         = '0;
    cdb_idx     = '0;
    rd1_idx     = '0;
    rd2_idx     = '0;
    store_read  = 1'b0;
    for (int s = 0; s < LB_DEPTH; s++) begin
      lb_idx[s]   = '0;
      lb_query[s] = '0;
    end
    repeat (10) @(posedge clk_in);
    #2;
    rst_in = 1'b0;
    test_reset_state();
    test_in_order_commit();
    test_full_backpressure();
    test_store_path();
    test_operand_lookup();
    test_load_check();
    test_mispredict_flush();
    $display("*** PASSED ***");
    $finish;
  end

endmodule
